//--- refcpu_isa_pkg.sv
`default_nettype none

package refcpu_isa_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int SHAMT_W  = 5;
    localparam int NUM_REGS = 1 << REG_W;

    typedef logic [REG_W-1:0]  reg_id_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] addr_t;

    localparam logic [OPCODE_W-1:0] OP_SPECIAL = 6'h00;  // R-type group.
    localparam reg_id_t             R0         = 5'd0;

    // Function field of SPECIAL instructions.
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_SLLV  = 6'h04,
        FN_SRLV  = 6'h06,
        FN_SRAV  = 6'h07,
        FN_JR    = 6'h08,
        FN_JALR  = 6'h09,
        FN_BREAK = 6'h0d,
        FN_ADD   = 6'h20,
        FN_ADDU  = 6'h21,
        FN_SUB   = 6'h22,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_t;

    typedef enum logic [4:0] {
        EX_NONE = 5'd0,
        EX_ADEL = 5'd4,   // Address error on fetch.
        EX_BP   = 5'd9,
        EX_RI   = 5'd10,
        EX_OV   = 5'd12
    } exc_code_t;

endpackage

`default_nettype wire

//--- refcpu_core_pkg.sv
`default_nettype none

package refcpu_core_pkg;

    import refcpu_isa_pkg::*;

    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_WB,
        S_HALT
    } ctrl_state_t;

    // What the executor asks writeback to do.
    typedef enum logic [1:0] {
        K_COMMIT,
        K_BRANCH,
        K_EXCEPTION
    } result_kind_t;

    typedef struct packed {
        addr_t pc;
        word_t instr;
        word_t rs_val;
        word_t rt_val;
    } exec_ctx_t;

endpackage

`default_nettype wire

//--- refcpu_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Control to executor, result valid in the same cycle.
interface exec_if;
    import refcpu_isa_pkg::*;
    import refcpu_core_pkg::*;

    exec_ctx_t    ctx;
    result_kind_t kind;
    reg_id_t      target_id;
    word_t        wdata;
    addr_t        new_pc;
    exc_code_t    exc_code;

    modport ctrl (output ctx, input kind, input target_id, input wdata,
                  input new_pc, input exc_code);
    modport exec (input ctx, output kind, output target_id, output wdata,
                  output new_pc, output exc_code);
endinterface

interface rf_if;
    import refcpu_isa_pkg::*;

    reg_id_t rs_id;
    reg_id_t rt_id;
    word_t   rs_val;
    word_t   rt_val;
    logic    we;
    reg_id_t wid;
    word_t   wdata;

    modport ctrl (output rs_id, output rt_id, input rs_val, input rt_val,
                  output we, output wid, output wdata);
    modport rf (input rs_id, input rt_id, output rs_val, output rt_val,
                input we, input wid, input wdata);
endinterface

`default_nettype wire

//--- instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  logic                                clk,
    input  logic                                we,
    input  logic [refcpu_core_pkg::IMEM_AW-1:0] waddr,
    input  refcpu_isa_pkg::word_t               wdata,
    input  logic                                fetch_en,
    input  logic [refcpu_core_pkg::IMEM_AW-1:0] fetch_addr,
    output refcpu_isa_pkg::word_t               fetch_data
);

    import refcpu_isa_pkg::*;
    import refcpu_core_pkg::*;

    word_t mem [IMEM_DEPTH];

    // Load port, open in every state.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Word holds between fetches.
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data <= mem[fetch_addr];
        end
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dbg_we,
    input  refcpu_isa_pkg::reg_id_t  dbg_addr,
    input  refcpu_isa_pkg::word_t    dbg_wdata,
    output refcpu_isa_pkg::word_t    dbg_rdata,
    rf_if.rf                         rf
);

    import refcpu_isa_pkg::*;

    word_t regs [NUM_REGS];

    // Writes to r0 are dropped, so it stays at its reset value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we) begin
            if (rf.wid != R0) begin
                regs[rf.wid] <= rf.wdata;
            end
        end else if (dbg_we && dbg_addr != R0) begin
            regs[dbg_addr] <= dbg_wdata;
        end
    end

    assign rf.rs_val = regs[rf.rs_id];
    assign rf.rt_val = regs[rf.rt_id];
    assign dbg_rdata = regs[dbg_addr];

    // Debug writes only while the core is stopped.
    a_no_write_clash: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rf.we && dbg_we)
    );

endmodule

`default_nettype wire

//--- rtype_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rtype_exec (
    exec_if.exec ex
);

    import refcpu_isa_pkg::*;
    import refcpu_core_pkg::*;

    // Operand values arrive already read, only rd is taken from the word.
    reg_id_t             rd;
    logic [SHAMT_W-1:0]  shamt;
    funct_t              funct;
    word_t               rs_val;
    word_t               rt_val;
    addr_t               link_pc;
    logic [WORD_W:0]     v_rs;
    logic [WORD_W:0]     v_rt;
    logic [WORD_W:0]     v_add;
    logic [WORD_W:0]     v_sub;
    logic                lt_s;
    logic                lt_u;

    assign rd     = ex.ctx.instr[15:11];
    assign shamt  = ex.ctx.instr[10:6];
    assign funct  = funct_t'(ex.ctx.instr[FUNCT_W-1:0]);
    assign rs_val = ex.ctx.rs_val;
    assign rt_val = ex.ctx.rt_val;

    assign link_pc = ex.ctx.pc + 32'd8;  // Skips the delay slot.

    assign v_rs  = {rs_val[WORD_W-1], rs_val};
    assign v_rt  = {rt_val[WORD_W-1], rt_val};
    assign v_add = v_rs + v_rt;
    assign v_sub = v_rs - v_rt;

    assign lt_s = $signed(rs_val) < $signed(rt_val);
    assign lt_u = rs_val < rt_val;

    always_comb begin
        ex.kind      = K_COMMIT;
        ex.target_id = rd;
        ex.wdata     = '0;
        ex.new_pc    = '0;
        ex.exc_code  = EX_NONE;

        unique case (funct)
            FN_SLL:  ex.wdata = rt_val << shamt;
            FN_SRL:  ex.wdata = rt_val >> shamt;
            FN_SRA:  ex.wdata = $signed(rt_val) >>> shamt;
            FN_SLLV: ex.wdata = rt_val << rs_val[4:0];
            FN_SRLV: ex.wdata = rt_val >> rs_val[4:0];
            FN_SRAV: ex.wdata = $signed(rt_val) >>> rs_val[4:0];
            FN_ADDU: ex.wdata = rs_val + rt_val;
            FN_SUBU: ex.wdata = rs_val - rt_val;
            FN_AND:  ex.wdata = rs_val & rt_val;
            FN_OR:   ex.wdata = rs_val | rt_val;
            FN_XOR:  ex.wdata = rs_val ^ rt_val;
            FN_NOR:  ex.wdata = ~(rs_val | rt_val);
            FN_SLT:  ex.wdata = {{(WORD_W-1){1'b0}}, lt_s};
            FN_SLTU: ex.wdata = {{(WORD_W-1){1'b0}}, lt_u};
            FN_ADD: begin
                if (v_add[WORD_W] != v_add[WORD_W-1]) begin  // Signed overflow.
                    ex.kind      = K_EXCEPTION;
                    ex.target_id = R0;
                    ex.exc_code  = EX_OV;
                end else begin
                    ex.wdata = v_add[WORD_W-1:0];
                end
            end
            FN_SUB: begin
                if (v_sub[WORD_W] != v_sub[WORD_W-1]) begin
                    ex.kind      = K_EXCEPTION;
                    ex.target_id = R0;
                    ex.exc_code  = EX_OV;
                end else begin
                    ex.wdata = v_sub[WORD_W-1:0];
                end
            end
            FN_JR: begin
                ex.kind      = K_BRANCH;
                ex.target_id = R0;  // No link.
                ex.new_pc    = rs_val;
            end
            FN_JALR: begin
                ex.kind   = K_BRANCH;
                ex.wdata  = link_pc;
                ex.new_pc = rs_val;
            end
            FN_BREAK: begin
                ex.kind      = K_EXCEPTION;
                ex.target_id = R0;
                ex.exc_code  = EX_BP;
            end
            default: begin
                ex.kind      = K_EXCEPTION;
                ex.target_id = R0;
                ex.exc_code  = EX_RI;
            end
        endcase
    end

    a_exc_has_code: assert final (ex.kind != K_EXCEPTION || ex.exc_code != EX_NONE);

endmodule

`default_nettype wire

//--- cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  refcpu_isa_pkg::word_t               fetch_data,
    output logic                                busy,
    output logic                                done,
    output refcpu_isa_pkg::exc_code_t           exc_code,
    output refcpu_isa_pkg::addr_t               epc,
    output logic                                fetch_en,
    output logic [refcpu_core_pkg::IMEM_AW-1:0] fetch_addr,
    rf_if.ctrl                                  rf,
    exec_if.ctrl                                ex
);

    import refcpu_isa_pkg::*;
    import refcpu_core_pkg::*;

    ctrl_state_t          state;
    addr_t                pc;
    logic                 ds_armed;    // Next writeback redirects to br_target.
    addr_t                br_target;
    logic                 pc_misaligned;
    logic [OPCODE_W-1:0]  opcode;

    result_kind_t         res_kind;
    reg_id_t              res_target;
    word_t                res_wdata;
    addr_t                res_new_pc;
    exc_code_t            res_exc;

    assign opcode        = fetch_data[31:26];
    assign pc_misaligned = pc[1:0] != 2'b00;

    assign fetch_en   = (state == S_FETCH) && !pc_misaligned;
    assign fetch_addr = pc[IMEM_AW+1:2];  // Wraps modulo memory depth.

    assign rf.rs_id = fetch_data[25:21];
    assign rf.rt_id = fetch_data[20:16];
    assign ex.ctx   = '{pc: pc, instr: fetch_data, rs_val: rf.rs_val, rt_val: rf.rt_val};

    assign rf.we    = (state == S_WB) && (res_kind != K_EXCEPTION) && (res_target != R0);
    assign rf.wid   = res_target;
    assign rf.wdata = res_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            pc       <= '0;
            ds_armed <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            exc_code <= EX_NONE;
            epc      <= '0;
        end else begin
            done <= 1'b0;
            unique case (state)
                S_IDLE, S_HALT: begin
                    if (start) begin
                        pc       <= '0;
                        ds_armed <= 1'b0;
                        busy     <= 1'b1;
                        state    <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (pc_misaligned) begin
                        exc_code <= EX_ADEL;
                        epc      <= pc;
                        done     <= 1'b1;
                        busy     <= 1'b0;
                        state    <= S_HALT;
                    end else begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: state <= S_WB;
                S_WB: begin
                    if (res_kind == K_EXCEPTION) begin
                        exc_code <= res_exc;
                        epc      <= pc;
                        done     <= 1'b1;
                        busy     <= 1'b0;
                        state    <= S_HALT;
                    end else begin
                        pc       <= ds_armed ? br_target : pc + 32'd4;
                        ds_armed <= (res_kind == K_BRANCH);
                        state    <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Executor result, captured once per instruction.
    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            if (opcode != OP_SPECIAL) begin
                res_kind   <= K_EXCEPTION;
                res_target <= R0;
                res_exc    <= EX_RI;
            end else begin
                res_kind   <= ex.kind;
                res_target <= ex.target_id;
                res_exc    <= ex.exc_code;
            end
            res_wdata  <= ex.wdata;
            res_new_pc <= ex.new_pc;
        end
        if (state == S_WB && res_kind == K_BRANCH) begin
            br_target <= res_new_pc;
        end
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

    // A write retires the instruction, the next fetch follows.
    a_write_in_wb: assert property (
        @(posedge clk) disable iff (!rst_n)
        rf.we |-> busy ##1 (state == S_FETCH)
    );

endmodule

`default_nettype wire

//--- refcpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module refcpu_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                imem_we,
    input  logic [refcpu_core_pkg::IMEM_AW-1:0] imem_addr,
    input  refcpu_isa_pkg::word_t               imem_wdata,
    input  logic                                dbg_we,
    input  refcpu_isa_pkg::reg_id_t             dbg_addr,
    input  refcpu_isa_pkg::word_t               dbg_wdata,
    output refcpu_isa_pkg::word_t               dbg_rdata,
    output logic                                busy,
    output logic                                done,
    output refcpu_isa_pkg::exc_code_t           exc_code,
    output refcpu_isa_pkg::addr_t               epc
);

    import refcpu_isa_pkg::*;
    import refcpu_core_pkg::*;

    logic                fetch_en;
    logic [IMEM_AW-1:0]  fetch_addr;
    word_t               fetch_data;

    exec_if ex_bus ();
    rf_if   rf_bus ();

    cpu_control i_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .fetch_data (fetch_data),
        .busy       (busy),
        .done       (done),
        .exc_code   (exc_code),
        .epc        (epc),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .rf         (rf_bus.ctrl),
        .ex         (ex_bus.ctrl)
    );

    instr_mem i_imem (
        .clk        (clk),
        .we         (imem_we),
        .waddr      (imem_addr),
        .wdata      (imem_wdata),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    reg_file i_rf (
        .clk       (clk),
        .rst_n     (rst_n),
        .dbg_we    (dbg_we),
        .dbg_addr  (dbg_addr),
        .dbg_wdata (dbg_wdata),
        .dbg_rdata (dbg_rdata),
        .rf        (rf_bus.rf)
    );

    rtype_exec i_exec (
        .ex (ex_bus.exec)
    );

endmodule

`default_nettype wire

//--- tb_refcpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_refcpu_core;

    import refcpu_isa_pkg::*;
    import refcpu_core_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG_NS = NUM_TESTS * 64 * 3 * 40 * 2;
    localparam int RUN_LIMIT   = IMEM_DEPTH * 3 + 8;  // Cycles allowed per run.

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    word_t              imem_wdata;
    logic               dbg_we;
    reg_id_t            dbg_addr;
    word_t              dbg_wdata;
    word_t              dbg_rdata;
    logic               busy;
    logic               done;
    exc_code_t          exc_code;
    addr_t              epc;

    integer             seed;
    int                 test_errors;
    int                 pass_count;
    int                 fail_count;
    logic [IMEM_AW-1:0] prog_ptr;
    word_t              model_regs [32];  // Expected register contents.

    refcpu_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_we     (dbg_we),
        .dbg_addr   (dbg_addr),
        .dbg_wdata  (dbg_wdata),
        .dbg_rdata  (dbg_rdata),
        .busy       (busy),
        .done       (done),
        .exc_code   (exc_code),
        .epc        (epc)
    );

    always #20 clk = ~clk;

    function automatic word_t encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    // Expected commit value of one R-type function.
    function automatic word_t model_alu(input logic [5:0] fn, input word_t rs,
                                        input word_t rt, input logic [4:0] sh);
        word_t r;
        case (fn)
            FN_SLL:  r = rt << sh;
            FN_SRL:  r = rt >> sh;
            FN_SRA:  r = (rt >> sh) | (rt[31] ? ~(32'hffffffff >> sh) : 32'h0);
            FN_SLLV: r = rt << rs[4:0];
            FN_SRLV: r = rt >> rs[4:0];
            FN_SRAV: r = (rt >> rs[4:0]) | (rt[31] ? ~(32'hffffffff >> rs[4:0]) : 32'h0);
            FN_ADDU: r = rs + rt;
            FN_SUBU: r = rs - rt;
            FN_AND:  r = rs & rt;
            FN_OR:   r = rs | rt;
            FN_XOR:  r = rs ^ rt;
            FN_NOR:  r = ~(rs | rt);
            FN_SLT:  r = (rs[31] != rt[31]) ? {31'b0, rs[31]} : {31'b0, rs < rt};
            FN_SLTU: r = {31'b0, rs < rt};
            default: r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic emit(input word_t word);
        @(negedge clk);
        imem_we    = 1'b1;
        imem_addr  = prog_ptr;
        imem_wdata = word;
        @(negedge clk);
        imem_we  = 1'b0;
        prog_ptr = prog_ptr + 1'b1;
    endtask

    task automatic set_reg(input reg_id_t id, input word_t val);
        @(negedge clk);
        dbg_we    = 1'b1;
        dbg_addr  = id;
        dbg_wdata = val;
        @(negedge clk);
        dbg_we = 1'b0;
        if (id != R0) begin
            model_regs[id] = val;
        end
    endtask

    task automatic read_reg(input reg_id_t id, output word_t val);
        @(negedge clk);
        dbg_addr = id;
        @(posedge clk);
        val = dbg_rdata;
    endtask

    task automatic check_all_regs();
        word_t v;
        for (int i = 0; i < 32; i++) begin
            read_reg(reg_id_t'(i), v);
            check_value($sformatf("r%0d", i), model_regs[i], v);
        end
    endtask

    // Start from pc 0 and wait for the halt.
    task automatic run_program(input exc_code_t exp_exc, input addr_t exp_epc);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("busy", 32'h1, {31'b0, busy});  // Raised by the start edge.
        while (!seen && cycles < RUN_LIMIT) begin
            if (done) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!seen) begin
            $display("FAIL: done never pulsed within %0d cycles of start", RUN_LIMIT);
            test_errors++;
        end else begin
            check_value("busy", 32'h0, {31'b0, busy});
            check_value("exc_code", exp_exc, exc_code);
            check_value("epc", exp_epc, epc);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("PASS test %0d: %s", num, name);
            pass_count++;
        end else begin
            $display("FAIL test %0d: %s (%0d errors)", num, name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic test_alu();
        logic [5:0] fns [14];
        reg_id_t    rs;
        reg_id_t    rt;
        logic [4:0] sh;
        fns = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU,
                FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
        check_value("busy", 32'h0, {31'b0, busy});  // Reset values.
        check_value("done", 32'h0, {31'b0, done});
        check_value("exc_code", EX_NONE, exc_code);
        check_value("epc", 32'h0, epc);
        for (int i = 1; i <= 4; i++) begin
            set_reg(reg_id_t'(i), $random(seed));
        end
        prog_ptr = '0;
        for (int i = 0; i < 14; i++) begin
            rs = (i % 2) ? 5'd3 : 5'd1;
            rt = (i % 2) ? 5'd4 : 5'd2;
            sh = $random(seed);
            emit(encode_rtype(rs, rt, reg_id_t'(10 + i), sh, fns[i]));
            model_regs[10 + i] = model_alu(fns[i], model_regs[rs], model_regs[rt], sh);
        end
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        run_program(EX_BP, 32'd56);
        check_all_regs();
        finish_test(1, "arithmetic and logic");
    endtask

    task automatic test_overflow();
        set_reg(1, 32'h7fffffff);
        set_reg(2, 32'h1);
        set_reg(4, 32'h1234abcd);
        prog_ptr = '0;
        emit(encode_rtype(1, 2, 3, 0, FN_ADDU));
        emit(encode_rtype(1, 2, 4, 0, FN_ADD));  // Halts, r4 keeps its value.
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        model_regs[3] = model_alu(FN_ADDU, model_regs[1], model_regs[2], 0);
        run_program(EX_OV, 32'd4);
        check_all_regs();
        set_reg(5, 32'h80000000);
        set_reg(6, 32'h1);
        set_reg(8, 32'h0badf00d);
        prog_ptr = '0;
        emit(encode_rtype(5, 6, 7, 0, FN_SUBU));
        emit(encode_rtype(5, 6, 8, 0, FN_SUB));
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        model_regs[7] = model_alu(FN_SUBU, model_regs[5], model_regs[6], 0);
        run_program(EX_OV, 32'd4);
        check_all_regs();
        finish_test(2, "overflow");
    endtask

    task automatic test_reg_zero();
        set_reg(0, 32'hffffffff);
        set_reg(9, 32'hdeadbeef);
        set_reg(11, 32'h55aa55aa);
        prog_ptr = '0;
        emit(encode_rtype(1, 2, 0, 0, FN_ADDU));
        emit(encode_rtype(0, 0, 0, 0, FN_NOR));
        emit(encode_rtype(0, 5, 9, 0, FN_ADDU));  // r0 as a source.
        emit(encode_rtype(0, 0, 11, 0, FN_OR));
        emit(encode_rtype(0, 1, 0, 3, FN_SLL));
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        model_regs[9]  = model_alu(FN_ADDU, model_regs[0], model_regs[5], 0);
        model_regs[11] = model_alu(FN_OR, model_regs[0], model_regs[0], 0);
        run_program(EX_BP, 32'd20);
        check_all_regs();
        finish_test(3, "register zero");
    endtask

    task automatic test_jumps();
        set_reg(20, 32'h40);
        set_reg(21, 32'h5);
        set_reg(14, 32'h0000cafe);
        prog_ptr = '0;
        emit(encode_rtype(20, 0, 31, 0, FN_JALR));
        emit(encode_rtype(21, 21, 13, 0, FN_ADDU));  // Delay slot.
        emit(encode_rtype(21, 21, 14, 0, FN_ADDU));
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        prog_ptr = 6'd16;
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        model_regs[31] = 32'd8;
        model_regs[13] = model_alu(FN_ADDU, model_regs[21], model_regs[21], 0);
        run_program(EX_BP, 32'h40);
        check_all_regs();
        set_reg(22, 32'h60);
        set_reg(31, 32'h77777777);
        set_reg(16, 32'h00001111);
        prog_ptr = '0;
        emit(encode_rtype(22, 0, 0, 0, FN_JR));
        emit(encode_rtype(21, 0, 15, 0, FN_SUBU));
        emit(encode_rtype(21, 21, 16, 0, FN_OR));
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        prog_ptr = 6'd24;
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        model_regs[15] = model_alu(FN_SUBU, model_regs[21], model_regs[0], 0);
        run_program(EX_BP, 32'h60);
        check_all_regs();
        finish_test(4, "jumps and delay slot");
    endtask

    task automatic test_faults();
        set_reg(18, 32'h18181818);
        set_reg(19, 32'h19191919);
        prog_ptr = '0;
        emit(encode_rtype(1, 2, 17, 0, FN_ADDU));
        emit(encode_rtype(1, 2, 18, 0, 6'h3f));  // Unknown funct.
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        model_regs[17] = model_alu(FN_ADDU, model_regs[1], model_regs[2], 0);
        run_program(EX_RI, 32'd4);
        check_all_regs();
        prog_ptr = '0;
        emit({6'h0f, 5'd1, 5'd2, 5'd19, 5'd0, 6'h21});
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        run_program(EX_RI, 32'd0);
        check_all_regs();
        set_reg(23, 32'h22);
        prog_ptr = '0;
        emit(encode_rtype(23, 0, 0, 0, FN_JR));
        emit(32'h0);
        emit(encode_rtype(0, 0, 0, 0, FN_BREAK));
        run_program(EX_ADEL, 32'h22);
        check_all_regs();
        finish_test(5, "faults");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_we     = 1'b0;
        dbg_addr   = '0;
        dbg_wdata  = '0;
        seed        = 99977;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        prog_ptr    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        test_alu();
        test_overflow();
        test_reg_zero();
        test_jumps();
        test_faults();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- refcpu_core.f
refcpu_isa_pkg.sv
refcpu_core_pkg.sv
refcpu_ifs.sv
instr_mem.sv
reg_file.sv
rtype_exec.sv
cpu_control.sv
refcpu_core.sv
tb_refcpu_core.sv
